// ==== bench/ex_stage_tests.svh ====
// directed tests for the execute stage, included into the testbench top

  logic [63:0] exp_q[$];

  // random item, ALU operands from op1 and op2, no control transfer
  function automatic id_to_ex_t new_item(input alu_op_e op, input logic word);
    id_to_ex_t it;
    it          = '0;
    it.pc       = rand_bits(62) << 2;
    it.rs1_data = rand_bits(64);
    it.rs2_data = rand_bits(64);
    it.op1      = rand_bits(64);
    it.op2      = rand_bits(64);
    it.imm      = rand_bits(64);
    it.alu_op   = op;
    it.is_word  = word;
    it.mem_rd   = 1'(rand_bits(1));
    it.mem_wr   = 1'(rand_bits(1));
    it.mem_size = 3'(rand_bits(3));
    it.rd_addr  = 5'(rand_bits(5));
    it.rd_wr    = 1'b1;
    return it;
  endfunction

  // reference results from the RV64 integer instruction definitions
  function automatic logic [63:0] alu_model(input alu_op_e op, input logic [63:0] a,
                                            input logic [63:0] b, input logic word);
    logic [31:0] w;
    logic [63:0] r;
    if (word) begin
      case (op)
        ADD:     w = a[31:0] + b[31:0];
        SUB:     w = a[31:0] - b[31:0];
        SLL:     w = a[31:0] << b[4:0];
        SRL:     w = a[31:0] >> b[4:0];
        default: w = $signed(a[31:0]) >>> b[4:0];
      endcase
      return {{32{w[31]}}, w};
    end
    case (op)
      ADD:     r = a + b;
      SUB:     r = a - b;
      SLL:     r = a << b[5:0];
      SLT:     r = {63'd0, $signed(a) < $signed(b)};
      SLTU:    r = {63'd0, a < b};
      XOR:     r = a ^ b;
      SRL:     r = a >> b[5:0];
      SRA:     r = $signed(a) >>> b[5:0];
      OR:      r = a | b;
      AND:     r = a & b;
      default: r = b;
    endcase
    return r;
  endfunction

  task automatic check_common(input ex_to_mem_t r, input id_to_ex_t it, input logic [63:0] sd);
    check_value(r.pc, it.pc, "pc");
    check_value(r.store_data, sd, "store_data");
    check_value({r.mem_rd, r.mem_wr, r.mem_size, r.rd_addr, r.rd_wr},
                {it.mem_rd, it.mem_wr, it.mem_size, it.rd_addr, it.rd_wr}, "mem and rd fields");
  endtask

  task automatic alu_case(input alu_op_e op, input logic word);
    id_to_ex_t it;
    it = new_item(op, word);
    // bit 5 set, so a word shift must ignore it
    if (word) begin
      it.op2[5] = 1'b1;
    end
    send_item(it);
    wait_for(1'b0, "ALU result");
    check_value(ex_to_mem.alu_result, alu_model(op, it.op1, it.op2, word), op.name());
    check_common(ex_to_mem, it, it.rs2_data);
  endtask

  task automatic alu_test();
    for (int k = 0; k <= 10; k++) begin
      alu_case(alu_op_e'(k), 1'b0);
    end
  endtask

  task automatic word_test();
    alu_op_e word_ops[5];
    word_ops = '{ADD, SUB, SLL, SRL, SRA};
    for (int k = 0; k < 15; k++) begin
      alu_case(word_ops[k % 5], 1'b1);
    end
  endtask

  // both sources read src, writers switched on by m_on and w_on
  task automatic fwd_case(input logic [4:0] src, input logic m_on, input logic w_on);
    id_to_ex_t   it;
    logic [63:0] vm;
    logic [63:0] vw;
    logic [63:0] va;
    logic [63:0] vb;
    it          = new_item(ADD, 1'b0);
    it.use_rs1  = 1'b1;
    it.use_rs2  = 1'b1;
    it.rs1_addr = src;
    it.rs2_addr = src;
    vm = rand_bits(64);
    vw = rand_bits(64);
    va = (src == 0) ? it.rs1_data : (m_on ? vm : vw);
    vb = (src == 0) ? it.rs2_data : (m_on ? vm : vw);
    @(posedge clk);
    mem_fwd <= {m_on, src, vm, 1'b0};
    wb_fwd  <= {w_on, src, vw, 1'b0};
    send_item(it);
    wait_for(1'b0, "forwarded result");
    check_value(ex_to_mem.alu_result, va + vb, "sum of forwarded operands");
    check_value(ex_to_mem.store_data, vb, "forwarded store data");
    @(posedge clk);
    mem_fwd <= '0;
    wb_fwd  <= '0;
  endtask

  task automatic fwd_test();
    fwd_case(5'd5, 1'b1, 1'b1);
    fwd_case(5'd6, 1'b0, 1'b1);
    fwd_case(5'd0, 1'b1, 1'b1);
  endtask

  task automatic hazard_test();
    id_to_ex_t   it;
    logic [63:0] vm;
    it          = new_item(ADD, 1'b0);
    it.use_rs1  = 1'b1;
    it.rs1_addr = 5'd9;
    vm = rand_bits(64);
    @(posedge clk);
    mem_fwd <= {1'b1, 5'd9, 64'd0, 1'b1};
    send_item(it);
    repeat (4) begin
      @(negedge clk);
      check_value(ex_to_mem_valid, 0, "ex_to_mem_valid during load-use stall");
      check_value(ex_allowin, 0, "ex_allowin during load-use stall");
    end
    // load data arrives
    @(posedge clk);
    mem_fwd <= {1'b1, 5'd9, vm, 1'b0};
    wait_for(1'b0, "result after load-use stall");
    check_value(ex_to_mem.alu_result, vm + it.op2, "result after load-use stall");
    @(posedge clk);
    mem_fwd <= '0;
  endtask

  task automatic branch_case(input bj_op_e op);
    id_to_ex_t   it;
    logic        tk;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] tgt;
    it       = new_item(ADD, 1'b0);
    it.bj_op = op;
    a        = it.rs1_data;
    if (rand_bits(1) != 0) begin
      it.rs2_data = a;
    end
    b = it.rs2_data;
    case (op)
      BEQ:     tk = (a == b);
      BNE:     tk = (a != b);
      BLT:     tk = ($signed(a) < $signed(b));
      BGE:     tk = ($signed(a) >= $signed(b));
      BLTU:    tk = (a < b);
      BGEU:    tk = (a >= b);
      default: tk = 1'b1;
    endcase
    tgt = (op == JALR) ? ((a + it.imm) & ~64'd1) : (it.pc + it.imm);
    @(posedge clk);
    if_bj_ready <= 1'b0;
    mem_allowin <= 1'b0;
    send_item(it);
    wait_for(1'b1, "redirect offer");
    check_value(redirect.taken, tk, {op.name(), " taken"});
    check_value(redirect.target, tgt, {op.name(), " target"});
    repeat (3) begin
      @(negedge clk);
      check_value(ex_to_mem_valid, 0, "ex_to_mem_valid before redirect handshake");
      check_value(redirect_valid, 1, "redirect_valid held while fetch is busy");
    end
    @(posedge clk);
    if_bj_ready <= 1'b1;
    // handshake edge, memory still stalled
    @(posedge clk);
    repeat (3) begin
      @(negedge clk);
      check_value(redirect_valid, 0, "redirect offered a second time");
      check_value(ex_to_mem_valid, 1, "ex_to_mem_valid after redirect");
    end
    @(posedge clk);
    mem_allowin <= 1'b1;
    wait_for(1'b0, "branch item result");
    check_value(ex_to_mem.alu_result,
                (op == JAL || op == JALR) ? it.pc + `INST_STEP : it.op1 + it.op2,
                "link or ALU result");
  endtask

  task automatic branch_test();
    for (int k = 1; k <= 8; k++) begin
      branch_case(bj_op_e'(k));
      branch_case(bj_op_e'(k));
    end
  endtask

  // ordered stream under random memory stalls
  task automatic stream_test();
    int         got;
    int         cyc;
    logic       held;
    ex_to_mem_t last;
    fork
      begin
        for (int k = 0; k < 8; k++) begin
          id_to_ex_t it;
          it = new_item(PASS2, 1'b0);
          exp_q.push_back(it.op2);
          send_item(it);
        end
      end
      begin
        got  = 0;
        cyc  = 0;
        held = 1'b0;
        while (got < 8 && cyc < 8 * TIMEOUT) begin
          @(posedge clk);
          mem_allowin <= 1'(rand_bits(1));
          @(negedge clk);
          cyc++;
          if (held) begin
            check_value(ex_to_mem == last, 1, "ex_to_mem stable under stall");
          end
          held = ex_to_mem_valid && !mem_allowin;
          last = ex_to_mem;
          if (held) begin
            check_value(ex_allowin, 0, "ex_allowin under stall");
          end
          if (ex_to_mem_valid && mem_allowin) begin
            got++;
            if (exp_q.size() == 0) begin
              report_error("an extra item reached the memory stage");
            end else begin
              check_value(ex_to_mem.alu_result, exp_q.pop_front(), "stream order");
            end
          end
        end
        if (got < 8) begin
          report_error("timed out waiting for the item stream");
        end
      end
    join
    @(posedge clk);
    mem_allowin <= 1'b1;
    // nothing may follow the last item
    repeat (4) begin
      @(negedge clk);
      if (ex_to_mem_valid) begin
        report_error("an item was repeated after the stream ended");
      end
    end
  endtask

// ==== bench/tb_ex_stage.sv ====
// execute stage testbench: clock, reset, DUT, LFSR stimulus, compare and report
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module tb_ex_stage;
  import rv_exec_pkg::*;

  localparam int TIMEOUT = 60;

  logic       clk;
  logic       rst;
  logic       id_to_ex_valid;
  id_to_ex_t  id_to_ex;
  logic       ex_allowin;
  logic       ex_to_mem_valid;
  ex_to_mem_t ex_to_mem;
  logic       mem_allowin;
  fwd_t       mem_fwd;
  fwd_t       wb_fwd;
  logic       redirect_valid;
  redirect_t  redirect;
  logic       if_bj_ready;

  logic [31:0] lfsr;
  int          err_cnt;
  int          n_pass;
  int          n_fail;
  int          base;

  ex_stage_top DUT (
    .clk             (clk),
    .rst             (rst),
    .id_to_ex_valid  (id_to_ex_valid),
    .id_to_ex        (id_to_ex),
    .ex_allowin      (ex_allowin),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_to_mem       (ex_to_mem),
    .mem_allowin     (mem_allowin),
    .mem_fwd         (mem_fwd),
    .wb_fwd          (wb_fwd),
    .redirect_valid  (redirect_valid),
    .redirect        (redirect),
    .if_bj_ready     (if_bj_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string why);
    err_cnt++;
    $display("ERROR at %0t ns: %s", $time, why);
  endtask

  task automatic test_done(input string name, input int first_err);
    if (err_cnt == first_err) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, err_cnt - first_err);
    end
  endtask

  // hold the item on the bus until the stage takes it
  task automatic send_item(input id_to_ex_t it);
    int n;
    @(posedge clk);
    id_to_ex_valid <= 1'b1;
    id_to_ex       <= it;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ex_allowin && n < TIMEOUT);
    if (!ex_allowin) begin
      report_error("the execute stage never accepted an item");
    end
    @(posedge clk);
    id_to_ex_valid <= 1'b0;
  endtask

  // redir picks the redirect offer, otherwise a transfer to memory
  task automatic wait_for(input logic redir, input string what);
    int   n;
    logic hit;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      hit = redir ? redirect_valid : (ex_to_mem_valid && mem_allowin);
    end while (!hit && n < TIMEOUT);
    if (!hit) begin
      report_error({"timed out waiting for ", what});
    end
  endtask

  `include "ex_stage_tests.svh"

  initial begin
    lfsr           = 32'd85494;
    err_cnt        = 0;
    n_pass         = 0;
    n_fail         = 0;
    rst            = 1'b1;
    id_to_ex_valid = 1'b0;
    id_to_ex       = '0;
    mem_allowin    = 1'b1;
    mem_fwd        = '0;
    wb_fwd         = '0;
    if_bj_ready    = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    base = err_cnt;
    check_value({ex_allowin, ex_to_mem_valid, redirect_valid}, 3'b100, "state after reset");
    test_done("reset", base);
    base = err_cnt;
    alu_test();
    test_done("alu", base);
    base = err_cnt;
    word_test();
    test_done("word", base);
    base = err_cnt;
    fwd_test();
    test_done("forwarding", base);
    base = err_cnt;
    hazard_test();
    test_done("load_use", base);
    base = err_cnt;
    branch_test();
    test_done("branch", base);
    base = err_cnt;
    stream_test();
    test_done("backpressure", base);
    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f rv_exec.f -o tb_ex_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== rv_exec.f ====
+incdir+src
+incdir+bench
src/rv_exec_pkg.sv
src/ex_operand_forward.sv
src/ex_alu.sv
src/ex_branch_unit.sv
src/ex_commit_ctrl.sv
src/ex_stage_top.sv
bench/tb_ex_stage.sv

// ==== src/ex_alu.sv ====
// integer ALU for the execute stage, with RV64 word forms
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module ex_alu (
  input  logic [`XLEN-1:0]    alu_a,
  input  logic [`XLEN-1:0]    alu_b,
  input  rv_exec_pkg::alu_op_e alu_op,
  input  logic                is_word,
  output logic [`XLEN-1:0]    alu_result
);
  import rv_exec_pkg::*;

  logic [5:0]       shamt;
  logic [`XLEN-1:0] srl_src;
  logic [`XLEN-1:0] sra_src;
  logic [`XLEN-1:0] raw;

  // word shifts use 5 bits of shift amount
  assign shamt = is_word ? {1'b0, alu_b[4:0]} : alu_b[5:0];

  // word right shifts act on the low half only
  assign srl_src = is_word ? {32'b0, alu_a[31:0]} : alu_a;
  assign sra_src = is_word ? {{32{alu_a[31]}}, alu_a[31:0]} : alu_a;

  always_comb begin
    case (alu_op)
      ADD: begin
        raw = alu_a + alu_b;
      end
      SUB: begin
        raw = alu_a - alu_b;
      end
      SLL: begin
        raw = alu_a << shamt;
      end
      SLT: begin
        raw = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      end
      SLTU: begin
        raw = {{(`XLEN-1){1'b0}}, alu_a < alu_b};
      end
      XOR: begin
        raw = alu_a ^ alu_b;
      end
      SRL: begin
        raw = srl_src >> shamt;
      end
      SRA: begin
        raw = $unsigned($signed(sra_src) >>> shamt);
      end
      OR: begin
        raw = alu_a | alu_b;
      end
      AND: begin
        raw = alu_a & alu_b;
      end
      PASS2: begin
        raw = alu_b;
      end
      default: begin
        raw = '0;
      end
    endcase
  end

  // word results are sign-extended from bit 31
  assign alu_result = is_word ? {{32{raw[31]}}, raw[31:0]} : raw;

  // decode must only hand over defined opcodes
  always_comb begin
    if (!$isunknown(alu_op)) begin
      assert (alu_op <= PASS2)
        else $error("undefined alu_op %0d", alu_op);
    end
  end

endmodule

// ==== src/ex_branch_unit.sv ====
// branch unit: condition evaluation and redirect target for branches and jumps
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module ex_branch_unit (
  input  logic                  ex_valid,
  input  rv_exec_pkg::bj_op_e   bj_op,
  input  logic [`XLEN-1:0]      rs1_val,
  input  logic [`XLEN-1:0]      rs2_val,
  input  logic [`XLEN-1:0]      pc,
  input  logic [`XLEN-1:0]      imm,
  output rv_exec_pkg::redirect_t redirect
);
  import rv_exec_pkg::*;

  logic             cond;
  logic [`XLEN-1:0] jalr_sum;

  always_comb begin
    case (bj_op)
      BEQ:  cond = (rs1_val == rs2_val);
      BNE:  cond = (rs1_val != rs2_val);
      BLT:  cond = ($signed(rs1_val) < $signed(rs2_val));
      BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
      BLTU: cond = (rs1_val < rs2_val);
      BGEU: cond = (rs1_val >= rs2_val);
      // jumps always redirect
      JAL:  cond = 1'b1;
      JALR: cond = 1'b1;
      default: begin
        cond = 1'b0;
      end
    endcase
  end

  assign jalr_sum = rs1_val + imm;

  // nothing redirects from an empty stage
  assign redirect.taken  = ex_valid && cond;
  // JALR target drops bit 0
  assign redirect.target = (bj_op == JALR) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + imm;

endmodule

// ==== src/ex_commit_ctrl.sv ====
// execute output side: ready-go, one redirect handshake per item, bus to memory
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module ex_commit_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ex_valid,
  input  rv_exec_pkg::id_to_ex_t  ex_item,
  input  logic [`XLEN-1:0]        alu_result,
  input  logic [`XLEN-1:0]        rs2_val,
  input  logic                    hazard,
  input  rv_exec_pkg::redirect_t  redirect_in,
  input  logic                    if_bj_ready,
  input  logic                    mem_allowin,
  output logic                    allowin,
  output logic                    ex_to_mem_valid,
  output rv_exec_pkg::ex_to_mem_t ex_to_mem,
  output logic                    redirect_valid,
  output rv_exec_pkg::redirect_t  redirect
);
  import rv_exec_pkg::*;

  logic redirect_done;
  logic has_bj;
  logic is_jump;
  logic bj_hs;
  logic ready_go;

  assign has_bj  = (ex_item.bj_op != NONE);
  assign is_jump = (ex_item.bj_op == JAL) || (ex_item.bj_op == JALR);

  // offered once operands are settled, withdrawn after the handshake
  assign redirect_valid = ex_valid && has_bj && !hazard && !redirect_done;
  assign redirect       = redirect_in;
  assign bj_hs          = redirect_valid && if_bj_ready;

  assign ready_go        = !hazard && (!has_bj || redirect_done || bj_hs);
  assign allowin         = !ex_valid || (ready_go && mem_allowin);
  assign ex_to_mem_valid = ex_valid && ready_go;

  // allowin high means the item leaves or the slot is empty
  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_done <= 1'b0;
    end else if (allowin) begin
      redirect_done <= 1'b0;
    end else if (bj_hs) begin
      redirect_done <= 1'b1;
    end
  end

  assign ex_to_mem.pc         = ex_item.pc;
  // jumps write the return address
  assign ex_to_mem.alu_result = is_jump ? ex_item.pc + `INST_STEP : alu_result;
  assign ex_to_mem.store_data = rs2_val;
  assign ex_to_mem.mem_rd     = ex_item.mem_rd;
  assign ex_to_mem.mem_wr     = ex_item.mem_wr;
  assign ex_to_mem.mem_size   = ex_item.mem_size;
  assign ex_to_mem.rd_addr    = ex_item.rd_addr;
  assign ex_to_mem.rd_wr      = ex_item.rd_wr;

  assert property (@(posedge clk) disable iff (rst)
    (ex_to_mem_valid && !mem_allowin) |=> $stable(ex_to_mem))
    else $error("ex_to_mem changed under back-pressure");

  // no second redirect offer before the item leaves
  assert property (@(posedge clk) disable iff (rst)
    (bj_hs && !allowin) |=> (!redirect_valid until_with allowin))
    else $error("redirect offered twice for one item");

endmodule

// ==== src/ex_operand_forward.sv ====
// execute input side: decode-to-execute register, operand forwarding, load-use hazard
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module ex_operand_forward (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      id_to_ex_valid,
  input  rv_exec_pkg::id_to_ex_t    id_to_ex,
  input  rv_exec_pkg::fwd_t         mem_fwd,
  input  rv_exec_pkg::fwd_t         wb_fwd,
  input  logic                      allowin,
  output logic                      ex_valid,
  output rv_exec_pkg::id_to_ex_t    ex_item,
  output rv_exec_pkg::ex_operands_t operands,
  output logic                      hazard
);
  import rv_exec_pkg::*;

  logic [`XLEN:0] rs1_pick;
  logic [`XLEN:0] rs2_pick;

  // nearest writer wins, result is {pending, value}
  function automatic logic [`XLEN:0] pick_src(
    input logic               use_src,
    input logic [`REG_AW-1:0] addr,
    input logic [`XLEN-1:0]   rf_val,
    input fwd_t               mf,
    input fwd_t               wf
  );
    logic [`XLEN:0] res;
    res = {1'b0, rf_val};
    // x0 is hardwired, never forwarded
    if (use_src && addr != '0) begin
      if (mf.wr_ena && mf.wr_addr == addr) begin
        res = {mf.data_pending, mf.wr_data};
      end else if (wf.wr_ena && wf.wr_addr == addr) begin
        res = {wf.data_pending, wf.wr_data};
      end
    end
    return res;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (allowin) begin
      ex_valid <= id_to_ex_valid;
    end
  end

  // payload only, captured on transfer
  always_ff @(posedge clk) begin
    if (id_to_ex_valid && allowin) begin
      ex_item <= id_to_ex;
    end
  end

  assign rs1_pick = pick_src(ex_item.use_rs1, ex_item.rs1_addr, ex_item.rs1_data,
                             mem_fwd, wb_fwd);
  assign rs2_pick = pick_src(ex_item.use_rs2, ex_item.rs2_addr, ex_item.rs2_data,
                             mem_fwd, wb_fwd);

  assign hazard = ex_valid && (rs1_pick[`XLEN] || rs2_pick[`XLEN]);

  assign operands.rs1_val = rs1_pick[`XLEN-1:0];
  assign operands.rs2_val = rs2_pick[`XLEN-1:0];
  // immediates or pc when the source is unused
  assign operands.alu_a   = ex_item.use_rs1 ? rs1_pick[`XLEN-1:0] : ex_item.op1;
  assign operands.alu_b   = ex_item.use_rs2 ? rs2_pick[`XLEN-1:0] : ex_item.op2;

  // a stalled item stays put until the hazard clears
  assert property (@(posedge clk) disable iff (rst)
    hazard |-> ex_valid ##1 (ex_valid && $stable(ex_item)))
    else $error("hazard without a held item");

endmodule

// ==== src/ex_stage_top.sv ====
// execute stage of the RV64 integer pipeline
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module ex_stage_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    id_to_ex_valid,
  input  rv_exec_pkg::id_to_ex_t  id_to_ex,
  output logic                    ex_allowin,
  output logic                    ex_to_mem_valid,
  output rv_exec_pkg::ex_to_mem_t ex_to_mem,
  input  logic                    mem_allowin,
  input  rv_exec_pkg::fwd_t       mem_fwd,
  input  rv_exec_pkg::fwd_t       wb_fwd,
  output logic                    redirect_valid,
  output rv_exec_pkg::redirect_t  redirect,
  input  logic                    if_bj_ready
);
  import rv_exec_pkg::*;

  logic             ex_valid;
  id_to_ex_t        ex_item;
  ex_operands_t     ex_operands;
  logic             hazard;
  logic [`XLEN-1:0] alu_result;
  redirect_t        bj_redirect;

  ex_operand_forward u_forward (
    .clk            (clk),
    .rst            (rst),
    .id_to_ex_valid (id_to_ex_valid),
    .id_to_ex       (id_to_ex),
    .mem_fwd        (mem_fwd),
    .wb_fwd         (wb_fwd),
    .allowin        (ex_allowin),
    .ex_valid       (ex_valid),
    .ex_item        (ex_item),
    .operands       (ex_operands),
    .hazard         (hazard)
  );

  ex_alu u_alu (
    .alu_a      (ex_operands.alu_a),
    .alu_b      (ex_operands.alu_b),
    .alu_op     (ex_item.alu_op),
    .is_word    (ex_item.is_word),
    .alu_result (alu_result)
  );

  ex_branch_unit u_branch (
    .ex_valid (ex_valid),
    .bj_op    (ex_item.bj_op),
    .rs1_val  (ex_operands.rs1_val),
    .rs2_val  (ex_operands.rs2_val),
    .pc       (ex_item.pc),
    .imm      (ex_item.imm),
    .redirect (bj_redirect)
  );

  ex_commit_ctrl u_commit (
    .clk             (clk),
    .rst             (rst),
    .ex_valid        (ex_valid),
    .ex_item         (ex_item),
    .alu_result      (alu_result),
    .rs2_val         (ex_operands.rs2_val),
    .hazard          (hazard),
    .redirect_in     (bj_redirect),
    .if_bj_ready     (if_bj_ready),
    .mem_allowin     (mem_allowin),
    .allowin         (ex_allowin),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_to_mem       (ex_to_mem),
    .redirect_valid  (redirect_valid),
    .redirect        (redirect)
  );

endmodule

// ==== src/rv_exec_params.svh ====
// execute stage parameters: data width, register address width, instruction step
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// data and address width
`define XLEN 64

// register file address width
`define REG_AW 5

// byte distance to the next instruction
`define INST_STEP 4

`endif

// ==== src/rv_exec_pkg.sv ====
// execute stage types: ALU and control-transfer opcodes, inter-stage buses
`include "rv_exec_params.svh"

package rv_exec_pkg;

  // integer operations, PASS2 carries operand 2 through for LUI
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS2
  } alu_op_e;

  // control transfers
  typedef enum logic [3:0] {
    NONE = 4'd0,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    JAL,
    JALR
  } bj_op_e;

  // decoded instruction from decode
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic               use_rs1;
    logic               use_rs2;
    // register file values as read in decode
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    // immediate or pc operands
    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    // branch and jump offset
    logic [`XLEN-1:0]   imm;
    alu_op_e            alu_op;
    bj_op_e             bj_op;
    logic               is_word;
    logic               mem_rd;
    logic               mem_wr;
    logic [2:0]         mem_size;
    logic [`REG_AW-1:0] rd_addr;
    logic               rd_wr;
  } id_to_ex_t;

  // pending register write of a later stage
  typedef struct packed {
    logic               wr_ena;
    logic [`REG_AW-1:0] wr_addr;
    logic [`XLEN-1:0]   wr_data;
    // value not known yet, e.g. load still in memory
    logic               data_pending;
  } fwd_t;

  // result handed to the memory stage
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   alu_result;
    logic [`XLEN-1:0]   store_data;
    logic               mem_rd;
    logic               mem_wr;
    logic [2:0]         mem_size;
    logic [`REG_AW-1:0] rd_addr;
    logic               rd_wr;
  } ex_to_mem_t;

  // fetch redirect
  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } redirect_t;

  // operands after forwarding
  typedef struct packed {
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
  } ex_operands_t;

endpackage
